/* Makefile */
.PHONY: run lint clean

run:
	verilator --binary --assert --top-module cpuTb -f verilog.f -o cpuSim
	obj_dir/cpuSim | tee /dev/stderr | grep -q "Done: no errors"

lint:
	verilator --lint-only -Wall --timing --top-module cpuWrapper -f verilog.f

clean:
	rm -rf obj_dir

/* design/alu.sv */
// Integer ALU: add, sub, and, or, shifts, plus signed compare flags for branches
module alu import isaPkg::*; (
    input  wordT       a,
    input  wordT       b,
    input  aluOpT      op,
    input  logic [4:0] shiftAmt,
    output wordT       result,
    output logic       notEqual,
    output logic       lessThan
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSll:  result = a << shiftAmt;                   // Shifts use shamt, not b
            aluSra:  result = wordT'($signed(a) >>> shiftAmt); // Sign fill
            default: result = '0;
        endcase
    end

    // Flags are independent of op
    assign notEqual = a != b;
    assign lessThan = $signed(a) < $signed(b);

endmodule

/* design/cpuWrapper.sv */
// CPU top: core plus register file, instruction and data memories, with program load port
module cpuWrapper import isaPkg::*, pipePkg::*; #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   loadEnable,
    input  wordT   loadAddr,
    input  wordT   loadData,
    output commitT commit // Writeback trace
);

    wordT   imemAddr;
    wordT   imemData;
    wordT   dmemAddr;
    wordT   dmemWriteData;
    wordT   dmemReadData;
    logic   dmemWrite;
    regIdxT readRegA;
    regIdxT readRegB;
    wordT   readDataA;
    wordT   readDataB;

    processor core (
        .clock, .reset, .imemAddr, .imemData, .dmemAddr, .dmemWriteData, .dmemWrite,
        .dmemReadData, .readRegA, .readRegB, .readDataA, .readDataB, .commit
    );

    regFile registers (
        .clock, .reset, .readRegA, .readRegB, .readDataA, .readDataB, .commit
    );

    // Instruction memory written only through the load port
    wordRam #(.depth(imemDepth)) imem (
        .clock, .writeEnable(loadEnable), .writeAddr(loadAddr), .writeData(loadData),
        .readAddr(imemAddr), .readData(imemData)
    );

    wordRam #(.depth(dmemDepth)) dmem (
        .clock, .writeEnable(dmemWrite), .writeAddr(dmemAddr), .writeData(dmemWriteData),
        .readAddr(dmemAddr), .readData(dmemReadData)
    );

endmodule

/* design/hazardUnit.sv */
// Hazard detection: load-use interlock and operand bypass selection
module hazardUnit import isaPkg::*, pipePkg::*; (
    input  wordT      decodeIr,
    input  wordT      execIr,
    input  wordT      memIr,
    input  wordT      writeIr,
    output logic      interlockStall,
    output bypassSelT aluASel,
    output bypassSelT aluBSel,
    output logic      storeBypass
);

    regIdxT decodeSrcA;
    regIdxT decodeSrcB;
    regIdxT execDest;
    regIdxT memDest;
    regIdxT writeDest;
    logic   execIsLoad;

    // Youngest producer wins
    function automatic bypassSelT pickSource(regIdxT src, regIdxT memDst, regIdxT writeDst);
        if (src == '0) return bypFile; // r0 never forwarded
        if (src == memDst) return bypMem;
        if (src == writeDst) return bypWrite;
        return bypFile;
    endfunction

    assign decodeSrcA = srcAOf(decodeIr);
    assign decodeSrcB = srcBOf(decodeIr);
    assign execDest   = destOf(execIr);
    assign memDest    = destOf(memIr);
    assign writeDest  = destOf(writeIr);
    assign execIsLoad = opcodeOf(execIr) == opLw;

    // Store data can wait for the writeback bypass, so sw data alone does not stall
    assign interlockStall = execIsLoad && execDest != '0
                            && (decodeSrcA == execDest
                                || (decodeSrcB == execDest && opcodeOf(decodeIr) != opSw));

    assign aluASel = pickSource(srcAOf(execIr), memDest, writeDest);
    assign aluBSel = pickSource(srcBOf(execIr), memDest, writeDest);

    // sw in memory whose data register is committing now
    assign storeBypass = opcodeOf(memIr) == opSw && writeDest != '0 && writeDest == rdOf(memIr);

endmodule

/* design/isaPkg.sv */
// Instruction set encoding: opcodes, ALU ops, field layout and register-use decoding
package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;

    typedef enum logic [4:0] {
        opRType = 5'b00000,
        opJ     = 5'b00001,
        opBne   = 5'b00010,
        opJal   = 5'b00011,
        opAddi  = 5'b00101,
        opBlt   = 5'b00110,
        opSw    = 5'b00111,
        opLw    = 5'b01000
    } opcodeT;

    typedef enum logic [4:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } aluOpT;

    // Field positions, low bit of each 5-bit field
    localparam int opcodeLsb   = 27;
    localparam int rdLsb       = 22;
    localparam int rsLsb       = 17;
    localparam int rtLsb       = 12;
    localparam int shamtLsb    = 7;
    localparam int aluOpLsb    = 2;
    localparam int fieldWidth  = 5;
    localparam int immWidth    = 17; // Sign-extended
    localparam int targetWidth = 27; // Absolute jump target

    localparam regIdxT linkReg = 5'd31; // jal return register

    function automatic opcodeT opcodeOf(wordT ir);
        return opcodeT'(ir[opcodeLsb +: fieldWidth]);
    endfunction

    function automatic regIdxT rdOf(wordT ir);
        return ir[rdLsb +: fieldWidth];
    endfunction

    function automatic regIdxT rsOf(wordT ir);
        return ir[rsLsb +: fieldWidth];
    endfunction

    function automatic regIdxT rtOf(wordT ir);
        return ir[rtLsb +: fieldWidth];
    endfunction

    function automatic logic [4:0] shamtOf(wordT ir);
        return ir[shamtLsb +: fieldWidth];
    endfunction

    function automatic aluOpT aluOpOf(wordT ir);
        return aluOpT'(ir[aluOpLsb +: fieldWidth]);
    endfunction

    function automatic wordT immOf(wordT ir);
        return {{(32 - immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};
    endfunction

    function automatic wordT targetOf(wordT ir);
        return wordT'(ir[targetWidth-1:0]);
    endfunction

    // First source: rd for branches (compared against rs)
    function automatic regIdxT srcAOf(wordT ir);
        case (opcodeOf(ir))
            opBne, opBlt:                return rdOf(ir);
            opRType, opAddi, opLw, opSw: return rsOf(ir);
            default:                     return '0;
        endcase
    endfunction

    // Second source: sw store data rides here too
    function automatic regIdxT srcBOf(wordT ir);
        case (opcodeOf(ir))
            opRType:      return rtOf(ir);
            opSw:         return rdOf(ir);
            opBne, opBlt: return rsOf(ir);
            default:      return '0;
        endcase
    endfunction

    // Zero means no register write
    function automatic regIdxT destOf(wordT ir);
        case (opcodeOf(ir))
            opRType, opAddi, opLw: return rdOf(ir);
            opJal:                 return linkReg;
            default:               return '0;
        endcase
    endfunction

endpackage

/* design/pipeLatch.sv */
// Stage register holding one pipeline payload, with hold and bubble insertion
module pipeLatch #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clock) begin
        if (reset) begin
            q <= '0; // All-zero word decodes as a no-op
        end else if (!stall) begin // Hold wins over flush
            q <= flush ? '0 : d;
        end
    end

endmodule

/* design/pipePkg.sv */
// Pipeline records: per-stage payloads, writeback commit and bypass source select
package pipePkg;
    import isaPkg::*;

    typedef struct packed {
        wordT ir;
        wordT pcPlusOne;
    } fetchDecodeT;

    typedef struct packed {
        wordT ir;
        wordT pcPlusOne;
        wordT regA;      // Register file read, port A
        wordT regB;
    } decodeExecT;

    typedef struct packed {
        wordT ir;
        wordT result;    // ALU output, or PC+1 for jal
        wordT storeData;
    } execMemT;

    typedef struct packed {
        wordT ir;
        wordT result;
        wordT loadData;
    } memWriteT;

    // Register write from writeback, also the external trace
    typedef struct packed {
        logic   valid;
        regIdxT dest;
        wordT   data;
    } commitT;

    typedef enum logic [1:0] {
        bypFile  = 2'd0,
        bypMem   = 2'd1,
        bypWrite = 2'd2
    } bypassSelT;

endpackage

/* design/processor.sv */
// Five-stage pipelined core with load-use interlock, bypassing and execute-stage branches
module processor import isaPkg::*, pipePkg::*; (
    input  logic   clock,
    input  logic   reset,
    output wordT   imemAddr,
    input  wordT   imemData,
    output wordT   dmemAddr,
    output wordT   dmemWriteData,
    output logic   dmemWrite,
    input  wordT   dmemReadData,
    output regIdxT readRegA,
    output regIdxT readRegB,
    input  wordT   readDataA,
    input  wordT   readDataB,
    output commitT commit
);

    wordT        pc;
    wordT        pcPlusOne;
    wordT        nextPc;
    wordT        branchTarget;
    logic        branchTaken;
    logic        interlockStall;
    logic        storeBypass;
    bypassSelT   aluASel;
    bypassSelT   aluBSel;
    fetchDecodeT fdIn, fd;
    decodeExecT  dxIn, dx;
    execMemT     xmIn, xm;
    memWriteT    mwIn, mw;
    opcodeT      execOp;
    aluOpT       execAluOp;
    wordT        execImm;
    wordT        operandA;
    wordT        operandB;
    wordT        aluB;
    wordT        aluResult;
    logic        notEqual;
    logic        lessThan;
    wordT        writeValue; // Final writeback data, also a bypass source

    hazardUnit hazards (
        .decodeIr(fd.ir), .execIr(dx.ir), .memIr(xm.ir), .writeIr(mw.ir),
        .interlockStall, .aluASel, .aluBSel, .storeBypass
    );

    // Fetch
    assign pcPlusOne = pc + 32'd1;
    assign nextPc    = branchTaken ? branchTarget : pcPlusOne;
    assign imemAddr  = pc;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (!interlockStall) begin // Refetch same word on interlock
            pc <= nextPc;
        end
    end

    assign fdIn = '{ir: imemData, pcPlusOne: pcPlusOne};
    pipeLatch #(.payloadT(fetchDecodeT)) fdLatch (
        .clock, .reset, .stall(interlockStall), .flush(branchTaken), .d(fdIn), .q(fd)
    );

    // Decode, register reads come back combinationally
    assign readRegA = srcAOf(fd.ir);
    assign readRegB = srcBOf(fd.ir);
    assign dxIn     = '{ir: fd.ir, pcPlusOne: fd.pcPlusOne, regA: readDataA, regB: readDataB};
    pipeLatch #(.payloadT(decodeExecT)) dxLatch (
        .clock, .reset, .stall(1'b0), .flush(interlockStall || branchTaken), .d(dxIn), .q(dx)
    );

    // Execute
    assign execOp    = opcodeOf(dx.ir);
    assign execImm   = immOf(dx.ir);
    assign execAluOp = (execOp == opRType) ? aluOpOf(dx.ir) : aluAdd; // Address math is add

    always_comb begin
        case (aluASel)
            bypMem:   operandA = xm.result;
            bypWrite: operandA = writeValue;
            default:  operandA = dx.regA;
        endcase
        case (aluBSel)
            bypMem:   operandB = xm.result;
            bypWrite: operandB = writeValue;
            default:  operandB = dx.regB;
        endcase
    end

    assign aluB = (execOp == opAddi || execOp == opLw || execOp == opSw) ? execImm : operandB;

    alu mainAlu (
        .a(operandA), .b(aluB), .op(execAluOp), .shiftAmt(shamtOf(dx.ir)),
        .result(aluResult), .notEqual, .lessThan
    );

    always_comb begin
        case (execOp)
            opBne:      branchTaken = notEqual; // rd != rs
            opBlt:      branchTaken = lessThan; // rd < rs
            opJ, opJal: branchTaken = 1'b1;
            default:    branchTaken = 1'b0;
        endcase
    end

    // Branches are PC-relative, jumps absolute
    assign branchTarget = (execOp == opBne || execOp == opBlt) ? dx.pcPlusOne + execImm
                                                               : targetOf(dx.ir);

    assign xmIn = '{ir: dx.ir,
                    result: (execOp == opJal) ? dx.pcPlusOne : aluResult,
                    storeData: operandB};
    pipeLatch #(.payloadT(execMemT)) xmLatch (
        .clock, .reset, .stall(1'b0), .flush(1'b0), .d(xmIn), .q(xm)
    );

    // Memory
    assign dmemAddr      = xm.result;
    assign dmemWriteData = storeBypass ? writeValue : xm.storeData; // Late store-data fix
    assign dmemWrite     = opcodeOf(xm.ir) == opSw;
    assign mwIn          = '{ir: xm.ir, result: xm.result, loadData: dmemReadData};
    pipeLatch #(.payloadT(memWriteT)) mwLatch (
        .clock, .reset, .stall(1'b0), .flush(1'b0), .d(mwIn), .q(mw)
    );

    // Writeback, r0 targets never commit
    assign writeValue = (opcodeOf(mw.ir) == opLw) ? mw.loadData : mw.result;
    assign commit     = '{valid: destOf(mw.ir) != '0, dest: destOf(mw.ir), data: writeValue};

endmodule

/* design/regFile.sv */
// Register file: 32 words, two combinational reads, one write, r0 fixed at zero
module regFile import isaPkg::*, pipePkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  regIdxT readRegA,
    input  regIdxT readRegB,
    output wordT   readDataA,
    output wordT   readDataB,
    input  commitT commit
);

    wordT regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (commit.valid && commit.dest != '0) begin
            regs[commit.dest] <= commit.data;
        end
    end

    // Same-cycle write is seen by decode
    assign readDataA = (readRegA == '0) ? '0
                     : (commit.valid && commit.dest == readRegA) ? commit.data : regs[readRegA];
    assign readDataB = (readRegB == '0) ? '0
                     : (commit.valid && commit.dest == readRegB) ? commit.data : regs[readRegB];

endmodule

/* design/wordRam.sv */
// Word memory with combinational read and clocked write, addresses wrap at depth
module wordRam import isaPkg::*; #(
    parameter int depth = 256
) (
    input  logic clock,
    input  logic writeEnable,
    input  wordT writeAddr,
    input  wordT writeData,
    input  wordT readAddr,
    output wordT readData
);

    localparam int addrWidth = $clog2(depth);

    wordT mem [depth];

    always_ff @(posedge clock) begin
        if (writeEnable) begin
            mem[addrWidth'(writeAddr % depth)] <= writeData;
        end
    end

    assign readData = mem[addrWidth'(readAddr % depth)]; // Same-cycle read

endmodule

/* sim/cpuTb.sv */
// Pipelined CPU testbench that loads a program and checks every register commit in order
module cpuTb
    import isaPkg::*, pipePkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clockPeriod = 8;
    localparam int resetCycles = 2;
    localparam int drainCycles = 10; // Idle tail to catch stray commits

    // One expected register write
    typedef struct packed {
        logic [7:0] test;
        regIdxT     dest;
        wordT       data;
    } expectT;

    logic   clock = 1'b0;
    logic   reset;
    logic   loadEnable;
    wordT   loadAddr;
    wordT   loadData;
    commitT commit;

    wordT   programWords[$]; // Instruction memory image from address 0
    expectT expected[$];     // Commit order as worked out by hand
    int     expCount;
    int     nextExp;         // Index of the next commit to match
    int     errorCount;
    int     passCount;
    int     failCount;
    logic   testHasError;
    logic   stimulusLoaded = 1'b0;

    cpuWrapper #(.imemDepth(64), .dmemDepth(64)) DUT (
        .clock, .reset, .loadEnable, .loadAddr, .loadData, .commit
    );

    always #(clockPeriod / 2) clock = ~clock;

    // Program words on I lines, expected commits on E lines, anything else skipped
    task automatic readStimulus();
        int    fd;
        int    testNum;
        int    regNum;
        wordT  value;
        string line;
        fd = $fopen("sim/programStimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/programStimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line[0] == "I" && $sscanf(line, "I %h", value) == 1) begin
                programWords.push_back(value);
            end else if (line[0] == "E"
                         && $sscanf(line, "E %d %d %h", testNum, regNum, value) == 3) begin
                expected.push_back('{test: 8'(testNum), dest: regIdxT'(regNum), data: value});
            end
        end
        $fclose(fd);
    endtask

    // Load port writes one word per edge while reset is still high
    task automatic loadProgram();
        repeat (resetCycles) @(posedge clock);
        foreach (programWords[i]) begin
            @(posedge clock);
            #1;
            loadEnable = 1'b1;
            loadAddr   = wordT'(i);
            loadData   = programWords[i];
        end
        @(posedge clock); // Last word written here
        #1;
        loadEnable = 1'b0;
        reset      = 1'b0; // Fetch from address 0 on the next edge
    endtask

    task automatic reportTest(logic [7:0] testNum);
        if (testHasError) begin
            failCount++;
            $display("Test %0d failed", testNum);
        end else begin
            passCount++;
            $display("Test %0d passed", testNum);
        end
        testHasError = 1'b0;
    endtask

    task automatic checkCommit(commitT seen);
        expectT want;
        assert (nextExp < expCount) else begin
            $display("Unexpected commit at %0t to r%0d = %h after the expected list ended",
                     $time, seen.dest, seen.data);
            errorCount++;
        end
        if (nextExp < expCount) begin
            want = expected[nextExp];
            assert (seen.dest == want.dest && seen.data == want.data) else begin
                $display("Mismatch at %0t: test %0d expected r%0d = %h, got r%0d = %h",
                         $time, want.test, want.dest, want.data, seen.dest, seen.data);
                errorCount++;
                testHasError = 1'b1;
            end
            nextExp++;
            // Last entry of this test
            if (nextExp == expCount || expected[nextExp].test != want.test) begin
                reportTest(want.test);
            end
        end
    endtask

    task automatic finishRun();
        $display("Tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    // Commit settles after the rising edge, so sample mid-cycle
    always @(negedge clock) begin
        if (!reset && commit.valid) begin
            checkCommit(commit);
        end
    end

    // Budget grows with program length and commit count
    initial begin
        wait (stimulusLoaded);
        #(clockPeriod * (programWords.size() + 4 * expCount + 20));
        $display("Timeout at %0t with %0d of %0d expected commits missing",
                 $time, expCount - nextExp, expCount);
        errorCount++;
        finishRun();
    end

    initial begin
        reset        = 1'b1;
        loadEnable   = 1'b0;
        loadAddr     = '0;
        loadData     = '0;
        nextExp      = 0;
        errorCount   = 0;
        passCount    = 0;
        failCount    = 0;
        testHasError = 1'b0;
        readStimulus();
        expCount       = expected.size();
        stimulusLoaded = 1'b1;
        if (programWords.size() == 0 || expCount == 0) begin
            $display("Stimulus file gave no program words or no expected commits");
            errorCount++;
        end else begin
            loadProgram();
            wait (nextExp == expCount); // Every expected commit seen
            repeat (drainCycles) @(posedge clock);
        end
        finishRun();
    end

endmodule

/* sim/programStimulus.txt */
# I lines hold one hex program word, loaded in address order from 0
# E lines hold test number, register and hex data, in expected commit order
I 28400005  # 0  addi r1, r0, 5
I 28820003  # 1  addi r2, r1, 3
I 00C22000  # 2  add r3, r1, r2
I 01061004  # 3  sub r4, r3, r1
I 01464008  # 4  and r5, r3, r4
I 018A100C  # 5  or r6, r5, r1
I 01CC0210  # 6  sll r7, r6, 4
I 2A01FFC0  # 7  addi r8, r0, -64
I 02500194  # 8  sra r9, r8, 3
I 39C0000A  # 9  sw r7, 10(r0)
I 4280000A  # 10 lw r10, 10(r0)
I 02D49000  # 11 add r11, r10, r9 after a load
I 2B00004D  # 12 addi r12, r0, 77
I 3B000014  # 13 sw r12, 20(r0)
I 43400014  # 14 lw r13, 20(r0)
I 43800014  # 15 lw r14, 20(r0)
I 3B800015  # 16 sw r14, 21(r0) with loaded data
I 43C00015  # 17 lw r15, 21(r0)
I 2C000001  # 18 addi r16, r0, 1
I 14000002  # 19 bne r16, r0, +2 taken
I 2C400063  # 20 skipped
I 2C400062  # 21 skipped
I 32000002  # 22 blt r8, r0, +2 taken
I 2C800061  # 23 skipped
I 2C800060  # 24 skipped
I 34000005  # 25 blt r16, r0, +5 not taken
I 14200005  # 26 bne r16, r16, +5 not taken
I 2CC00003  # 27 addi r19, r0, 3
I 0800001F  # 28 j 31
I 2D00000B  # 29 skipped
I 2D00000C  # 30 skipped
I 18000022  # 31 jal 34
I 2D40000D  # 32 skipped
I 2D40000E  # 33 skipped
I 05BE0000  # 34 add r22, r31, r0
I 28000037  # 35 addi r0, r0, 55
I 05C01000  # 36 add r23, r0, r1
I 08000025  # 37 j 37
E 1 1 00000005
E 1 2 00000008
E 1 3 0000000d
E 1 4 00000008
E 1 5 00000008
E 1 6 0000000d
E 1 7 000000d0
E 1 8 ffffffc0
E 1 9 fffffff8
E 2 10 000000d0
E 2 11 000000c8
E 3 12 0000004d
E 3 13 0000004d
E 3 14 0000004d
E 3 15 0000004d
E 4 16 00000001
E 4 19 00000003
E 5 31 00000020
E 5 22 00000020
E 6 23 00000005

/* verilog.f */
design/isaPkg.sv
design/pipePkg.sv
design/pipeLatch.sv
design/hazardUnit.sv
design/alu.sv
design/processor.sv
design/regFile.sv
design/wordRam.sv
design/cpuWrapper.sv
sim/cpuTb.sv
